/* include/rename_defines.svh */
/*
  rename defines
  register counts and index widths shared by the rename slice.
*/
`ifndef RENAME_DEFINES_SVH
`define RENAME_DEFINES_SVH

//////////////////////////////////////////////////
// register file sizes
//////////////////////////////////////////////////
`define RN_ARCH_REGS 32  // architectural registers x0..x31.
`define RN_PHYS_REGS 64  // physical register file entries.

//////////////////////////////////////////////////
// index widths
//////////////////////////////////////////////////
`define RN_ARCH_W 5      // log2 of RN_ARCH_REGS.
`define RN_PHYS_W 6      // log2 of RN_PHYS_REGS.

// ids not held by the map at reset live in the freelist.
`define RN_FREE_SIZE (`RN_PHYS_REGS - `RN_ARCH_REGS)

`endif

/* src/rename_pkg.sv */
/*
  rename package
  register index types and the request / renamed-op structs.
*/
`include "rename_defines.svh"

package rename_pkg;

  //////////////////////////////////////////////////
  // register index types
  //////////////////////////////////////////////////

  // architectural register index.
  typedef logic [`RN_ARCH_W-1:0] arch_reg_t;

  // physical register id.
  typedef logic [`RN_PHYS_W-1:0] phys_reg_t;

  //////////////////////////////////////////////////
  // rename request and result
  //////////////////////////////////////////////////

  // incoming decoded op, only the register fields matter here.
  typedef struct packed {
    arch_reg_t rs1;    // first source.
    arch_reg_t rs2;    // second source.
    arch_reg_t rd;     // destination.
    logic      rd_wr;  // op writes rd.
  } rn_req_t;

  // renamed op handed to dispatch.
  typedef struct packed {
    phys_reg_t prs1;       // physical id of rs1.
    phys_reg_t prs2;       // physical id of rs2.
    phys_reg_t prd;        // freshly allocated id for rd.
    phys_reg_t old_prd;    // previous mapping of rd, freed at commit.
    logic      prd_valid;  // prd / old_prd carry meaning.
  } rn_op_t;

endpackage

/* src/phys_freelist.sv */
/*
  physical register freelist
  circular fifo of free physical ids, one pop and one push per cycle.
*/
`timescale 1ns/1ps

module phys_freelist #(
  parameter int SIZE  = 32,
  parameter int WIDTH = 6,
  parameter int INIT  = 32
) (
  input  logic             i_clk,
  input  logic             i_reset_n,

  input  logic             i_push,     // return a retired id.
  input  logic [WIDTH-1:0] i_push_id,

  input  logic             i_pop,      // consume the head id.
  output logic [WIDTH-1:0] o_pop_id,

  output logic             o_is_empty
);

  localparam int PTR_W = (SIZE > 1) ? $clog2(SIZE) : 1;

  //////////////////////////////////////////////////
  // storage and pointers
  //////////////////////////////////////////////////
  logic [WIDTH-1:0] r_ids [SIZE];  // id slots.
  logic [PTR_W-1:0] r_head_ptr;    // next id to hand out.
  logic [PTR_W-1:0] r_tail_ptr;    // next free slot for a push.
  logic [SIZE-1:0]  r_active;      // slot holds a valid id.

  logic [PTR_W-1:0] w_head_nxt;
  logic [PTR_W-1:0] w_tail_nxt;

  // wrap explicitly so non power of two depths work.
  assign w_head_nxt = (r_head_ptr == PTR_W'(SIZE - 1)) ? '0 : r_head_ptr + 1'b1;
  assign w_tail_nxt = (r_tail_ptr == PTR_W'(SIZE - 1)) ? '0 : r_tail_ptr + 1'b1;

  //////////////////////////////////////////////////
  // pointer and occupancy update
  //////////////////////////////////////////////////
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_head_ptr <= '0;
      r_tail_ptr <= '0;   // list starts full so tail wraps onto head.
      r_active   <= '1;
      for (int i = 0; i < SIZE; i++) begin
        r_ids[i] <= WIDTH'(INIT + i);  // ids INIT .. INIT+SIZE-1 in order.
      end
    end else begin
      if (i_pop) begin
        r_head_ptr           <= w_head_nxt;
        r_active[r_head_ptr] <= 1'b0;
      end
      // push comes after pop so a refill of the same slot keeps it active.
      if (i_push) begin
        r_tail_ptr           <= w_tail_nxt;
        r_active[r_tail_ptr] <= 1'b1;
        r_ids[r_tail_ptr]    <= i_push_id;
      end
    end
  end

  //////////////////////////////////////////////////
  // outputs
  //////////////////////////////////////////////////
  assign o_pop_id   = r_ids[r_head_ptr];  // head is visible before the pop.
  assign o_is_empty = ~(|r_active);

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  // the consumer must look at o_is_empty before popping.
  a_no_pop_empty : assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    i_pop |-> !o_is_empty
  ) else $error("freelist popped while empty");

  // more ids returned than were handed out means a double commit.
  a_no_push_full : assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    (i_push && (&r_active)) |-> i_pop
  ) else $error("freelist pushed while full");

endmodule

/* src/rename_map_table.sv */
/*
  rename map table
  architectural to physical mapping, three read ports and one write port.
*/
`timescale 1ns/1ps
`include "rename_defines.svh"

module rename_map_table (
  input  logic                  i_clk,
  input  logic                  i_reset_n,

  // read side, all combinational.
  input  rename_pkg::arch_reg_t i_rs1,
  input  rename_pkg::arch_reg_t i_rs2,
  input  rename_pkg::arch_reg_t i_rd,
  output rename_pkg::phys_reg_t o_prs1,
  output rename_pkg::phys_reg_t o_prs2,
  output rename_pkg::phys_reg_t o_old_prd,

  // write side, lands at the clock edge.
  input  logic                  i_wr_en,
  input  rename_pkg::arch_reg_t i_wr_idx,
  input  rename_pkg::phys_reg_t i_wr_pid
);

  //////////////////////////////////////////////////
  // mapping storage
  //////////////////////////////////////////////////
  rename_pkg::phys_reg_t r_map [`RN_ARCH_REGS];  // current id per arch reg.

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      // identity map, arch i lives in phys i.
      for (int i = 0; i < `RN_ARCH_REGS; i++) begin
        r_map[i] <= rename_pkg::phys_reg_t'(i);
      end
    end else if (i_wr_en) begin
      r_map[i_wr_idx] <= i_wr_pid;  // visible to the next request.
    end
  end

  //////////////////////////////////////////////////
  // read ports
  //////////////////////////////////////////////////

  // reads see the mapping before this cycle's write.
  // same-op sources therefore read the old value, as they should.
  assign o_prs1    = r_map[i_rs1];
  assign o_prs2    = r_map[i_rs2];
  assign o_old_prd = r_map[i_rd];  // becomes old_prd of the renamed op.

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  // x0 is hardwired, its mapping must stay at phys 0 forever.
  a_no_wr_x0 : assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    i_wr_en |-> (i_wr_idx != '0)
  ) else $error("map table write to x0");

endmodule

/* src/rename_stage.sv */
/*
  rename stage
  merges map reads with the freelist head into one registered renamed op.
*/
`timescale 1ns/1ps

module rename_stage (
  input  logic                  i_clk,
  input  logic                  i_reset_n,

  // request side.
  input  logic                  i_rn_valid,
  input  rename_pkg::rn_req_t   i_rn_req,
  output logic                  o_rn_stall,

  // map table reads.
  output rename_pkg::arch_reg_t o_map_rs1,
  output rename_pkg::arch_reg_t o_map_rs2,
  output rename_pkg::arch_reg_t o_map_rd,
  input  rename_pkg::phys_reg_t i_map_prs1,
  input  rename_pkg::phys_reg_t i_map_prs2,
  input  rename_pkg::phys_reg_t i_map_old_prd,

  // freelist head.
  input  rename_pkg::phys_reg_t i_free_id,
  input  logic                  i_free_empty,
  output logic                  o_free_pop,

  // map table write.
  output logic                  o_map_wr_en,
  output rename_pkg::arch_reg_t o_map_wr_idx,
  output rename_pkg::phys_reg_t o_map_wr_pid,

  // renamed op.
  output logic                  o_rn_valid,
  output rename_pkg::rn_op_t    o_rn_op
);

  logic               w_has_dst;  // op really writes a register.
  logic               w_accept;   // request taken at this edge.
  logic               w_alloc;    // accept that needs a new id.
  rename_pkg::rn_op_t w_op;
  logic               r_rn_valid;
  rename_pkg::rn_op_t r_rn_op;

  //////////////////////////////////////////////////
  // decode and handshake
  //////////////////////////////////////////////////
  assign w_has_dst  = i_rn_req.rd_wr && (i_rn_req.rd != '0);  // x0 writes are dropped.
  assign o_rn_stall = i_rn_valid && w_has_dst && i_free_empty;
  assign w_accept   = i_rn_valid && !o_rn_stall;
  assign w_alloc    = w_accept && w_has_dst;

  // map lookups straight from the request fields.
  assign o_map_rs1 = i_rn_req.rs1;
  assign o_map_rs2 = i_rn_req.rs2;
  assign o_map_rd  = i_rn_req.rd;

  // pop the head id and bind it to rd in the same cycle.
  assign o_free_pop   = w_alloc;
  assign o_map_wr_en  = w_alloc;
  assign o_map_wr_idx = i_rn_req.rd;
  assign o_map_wr_pid = i_free_id;

  //////////////////////////////////////////////////
  // op assembly
  //////////////////////////////////////////////////
  always_comb begin
    w_op.prs1      = i_map_prs1;
    w_op.prs2      = i_map_prs2;
    w_op.prd_valid = w_has_dst;
    w_op.prd       = w_has_dst ? i_free_id : '0;      // zeroed when nothing is written.
    w_op.old_prd   = w_has_dst ? i_map_old_prd : '0;
  end

  //////////////////////////////////////////////////
  // output register
  //////////////////////////////////////////////////
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_rn_valid <= 1'b0;
    end else begin
      r_rn_valid <= w_accept;  // one pulse per accepted request.
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_accept) begin
      r_rn_op <= w_op;  // payload only moves with a valid request.
    end
  end

  assign o_rn_valid = r_rn_valid;
  assign o_rn_op    = r_rn_op;

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  // a fresh id never equals the mapping it replaces, else a live id was freed twice.
  a_fresh_prd : assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    (o_rn_valid && o_rn_op.prd_valid) |-> (o_rn_op.prd != o_rn_op.old_prd)
  ) else $error("renamed op got back the id it replaces");

endmodule

/* src/rename_top.sv */
/*
  rename top
  single-wide register rename with map table, freelist and commit return port.
*/
`timescale 1ns/1ps
`include "rename_defines.svh"

module rename_top (
  input  logic                  i_clk,
  input  logic                  i_reset_n,

  // rename request.
  input  logic                  i_rn_valid,
  input  rename_pkg::rn_req_t   i_rn_req,
  output logic                  o_rn_stall,

  // renamed op, one cycle after accept.
  output logic                  o_rn_valid,
  output rename_pkg::rn_op_t    o_rn_op,

  // commit returns a retired old id.
  input  logic                  i_commit_valid,
  input  rename_pkg::phys_reg_t i_commit_pid
);

  //////////////////////////////////////////////////
  // internal nets
  //////////////////////////////////////////////////
  rename_pkg::arch_reg_t w_map_rs1;
  rename_pkg::arch_reg_t w_map_rs2;
  rename_pkg::arch_reg_t w_map_rd;
  rename_pkg::phys_reg_t w_map_prs1;
  rename_pkg::phys_reg_t w_map_prs2;
  rename_pkg::phys_reg_t w_map_old_prd;

  logic                  w_map_wr_en;
  rename_pkg::arch_reg_t w_map_wr_idx;
  rename_pkg::phys_reg_t w_map_wr_pid;

  rename_pkg::phys_reg_t w_free_id;  // freelist head.
  logic                  w_free_empty;
  logic                  w_free_pop;

  //////////////////////////////////////////////////
  // freelist, non-architectural ids only
  //////////////////////////////////////////////////
  phys_freelist #(
    .SIZE  (`RN_FREE_SIZE),
    .WIDTH (`RN_PHYS_W),
    .INIT  (`RN_ARCH_REGS)
  ) u_freelist (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_push     (i_commit_valid),  // commit goes straight to the push side.
    .i_push_id  (i_commit_pid),
    .i_pop      (w_free_pop),
    .o_pop_id   (w_free_id),
    .o_is_empty (w_free_empty)
  );

  //////////////////////////////////////////////////
  // map table
  //////////////////////////////////////////////////
  rename_map_table u_map_table (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_rs1     (w_map_rs1),
    .i_rs2     (w_map_rs2),
    .i_rd      (w_map_rd),
    .o_prs1    (w_map_prs1),
    .o_prs2    (w_map_prs2),
    .o_old_prd (w_map_old_prd),
    .i_wr_en   (w_map_wr_en),
    .i_wr_idx  (w_map_wr_idx),
    .i_wr_pid  (w_map_wr_pid)
  );

  //////////////////////////////////////////////////
  // rename stage
  //////////////////////////////////////////////////
  rename_stage u_stage (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_rn_valid    (i_rn_valid),
    .i_rn_req      (i_rn_req),
    .o_rn_stall    (o_rn_stall),
    .o_map_rs1     (w_map_rs1),
    .o_map_rs2     (w_map_rs2),
    .o_map_rd      (w_map_rd),
    .i_map_prs1    (w_map_prs1),
    .i_map_prs2    (w_map_prs2),
    .i_map_old_prd (w_map_old_prd),
    .i_free_id     (w_free_id),
    .i_free_empty  (w_free_empty),
    .o_free_pop    (w_free_pop),
    .o_map_wr_en   (w_map_wr_en),
    .o_map_wr_idx  (w_map_wr_idx),
    .o_map_wr_pid  (w_map_wr_pid),
    .o_rn_valid    (o_rn_valid),
    .o_rn_op       (o_rn_op)
  );

endmodule

/* sim/tb_rename_top.sv */
/*
  rename top testbench
  directed and xorshift tests against a map table and freelist model.
*/
`timescale 1ns/1ps
`include "rename_defines.svh"

module tb_rename_top;

  localparam int VALID_TIMEOUT = 20;  // cycles allowed for o_rn_valid.

  logic                  i_clk;
  logic                  i_reset_n;
  logic                  i_rn_valid;
  rename_pkg::rn_req_t   i_rn_req;
  logic                  o_rn_stall;
  logic                  o_rn_valid;
  rename_pkg::rn_op_t    o_rn_op;
  logic                  i_commit_valid;
  rename_pkg::phys_reg_t i_commit_pid;

  // reference model state.
  rename_pkg::phys_reg_t model_map [`RN_ARCH_REGS];  // arch to phys.
  rename_pkg::phys_reg_t model_free [$];             // free ids, fifo order.
  rename_pkg::phys_reg_t model_held [$];             // old ids waiting for commit.

  int          mismatch_count;
  int          other_count;
  int          check_count;
  logic [31:0] rng_state;

  rename_top DUT (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_rn_valid     (i_rn_valid),
    .i_rn_req       (i_rn_req),
    .o_rn_stall     (o_rn_stall),
    .o_rn_valid     (o_rn_valid),
    .o_rn_op        (o_rn_op),
    .i_commit_valid (i_commit_valid),
    .i_commit_pid   (i_commit_pid)
  );

  initial begin
    i_clk = 1'b0;
    forever #2 i_clk = ~i_clk;  // 4 ns period.
  end

  //////////////////////////////////////////////////
  // helpers and reference model
  //////////////////////////////////////////////////
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // only a write to a nonzero rd allocates.
  function automatic logic writes_dst(input rename_pkg::rn_req_t req);
    return req.rd_wr && (req.rd != '0);
  endfunction

  function automatic rename_pkg::rn_req_t make_req(input int rs1, input int rs2,
                                                   input int rd, input logic wr);
    rename_pkg::rn_req_t req;
    req.rs1   = rename_pkg::arch_reg_t'(rs1);
    req.rs2   = rename_pkg::arch_reg_t'(rs2);
    req.rd    = rename_pkg::arch_reg_t'(rd);
    req.rd_wr = wr;
    return req;
  endfunction

  task automatic model_reset();
    model_free.delete();
    model_held.delete();
    for (int i = 0; i < `RN_ARCH_REGS; i++) begin
      model_map[i] = rename_pkg::phys_reg_t'(i);  // identity after reset.
    end
    for (int i = 0; i < `RN_FREE_SIZE; i++) begin
      model_free.push_back(rename_pkg::phys_reg_t'(`RN_ARCH_REGS + i));
    end
  endtask

  // predicts the op and applies its effect, sources read before the write.
  task automatic model_rename(input rename_pkg::rn_req_t req, output rename_pkg::rn_op_t op);
    op.prs1      = model_map[req.rs1];
    op.prs2      = model_map[req.rs2];
    op.prd_valid = writes_dst(req);
    op.prd       = '0;
    op.old_prd   = '0;
    if (op.prd_valid) begin
      op.prd          = model_free.pop_front();
      op.old_prd      = model_map[req.rd];
      model_map[req.rd] = op.prd;
      model_held.push_back(op.old_prd);
    end
  endtask

  //////////////////////////////////////////////////
  // compare tasks
  //////////////////////////////////////////////////
  task automatic check_op(input rename_pkg::rn_op_t actual, input rename_pkg::rn_op_t expected,
                          input string what);
    check_count++;
    if (actual !== expected) begin
      mismatch_count++;
      $display(
        "Mismatch at %0t: %s got {%0d %0d %0d %0d %0b} expected {%0d %0d %0d %0d %0b}",
        $time, what, actual.prs1, actual.prs2, actual.prd, actual.old_prd, actual.prd_valid,
        expected.prs1, expected.prs2, expected.prd, expected.old_prd, expected.prd_valid);
    end
  endtask

  task automatic check_stall(input logic actual, input logic expected, input string what);
    check_count++;
    if (actual !== expected) begin
      mismatch_count++;
      $display("Mismatch at %0t: %s stall got %b expected %b", $time, what, actual, expected);
    end
  endtask

  //////////////////////////////////////////////////
  // drivers, all entered and left on a falling edge
  //////////////////////////////////////////////////
  task automatic rename_one(input rename_pkg::rn_req_t req, input string what);
    rename_pkg::rn_op_t expected;
    int                 waited;
    i_rn_valid = 1'b1;
    i_rn_req   = req;
    #1;                                      // stall is combinational.
    check_stall(o_rn_stall, 1'b0, what);
    model_rename(req, expected);
    @(posedge i_clk);                        // accept.
    @(negedge i_clk);
    i_rn_valid = 1'b0;
    waited     = 0;
    while (!o_rn_valid && waited < VALID_TIMEOUT) begin
      @(negedge i_clk);
      waited++;
    end
    if (!o_rn_valid) begin
      other_count++;
      $display("timeout at %0t: no renamed op came back for %s", $time, what);
    end else begin
      if (waited != 0) begin
        other_count++;
        $display("error at %0t: renamed op for %s came %0d cycles late", $time, what, waited);
      end
      check_op(o_rn_op, expected, what);
    end
  endtask

  // request that must be refused, held for one cycle.
  task automatic stalled_request(input rename_pkg::rn_req_t req, input string what);
    i_rn_valid = 1'b1;
    i_rn_req   = req;
    #1;
    check_stall(o_rn_stall, 1'b1, what);
    @(posedge i_clk);
    @(negedge i_clk);
    i_rn_valid = 1'b0;
    if (o_rn_valid) begin
      other_count++;
      $display("error at %0t: a renamed op came out of stalled %s", $time, what);
    end
  endtask

  task automatic commit_id(input rename_pkg::phys_reg_t pid);
    i_commit_valid = 1'b1;
    i_commit_pid   = pid;
    @(posedge i_clk);
    @(negedge i_clk);
    i_commit_valid = 1'b0;
    model_free.push_back(pid);  // back of the fifo.
  endtask

  //////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////
  task automatic test_reset_identity();
    for (int i = 0; i < `RN_ARCH_REGS; i++) begin
      rename_one(make_req(i, (i * 7) % 32, i, 1'b0), "identity");
    end
  endtask

  task automatic test_alloc_order();
    for (int i = 1; i <= 6; i++) begin
      rename_one(make_req(0, 0, i, 1'b1), "alloc");
    end
    rename_one(make_req(0, 0, 3, 1'b1), "realloc x3");  // old_prd is the id from above.
  endtask

  // back to back, the second op reads the first op's rd.
  task automatic test_dependency();
    rename_one(make_req(0, 0, 5, 1'b1), "dep write x5");
    rename_one(make_req(5, 5, 6, 1'b1), "dep read x5");
    rename_one(make_req(6, 5, 6, 1'b1), "dep read x6");
  endtask

  task automatic test_no_alloc();
    rename_one(make_req(3, 4, 0, 1'b1), "write x0");
    rename_one(make_req(3, 4, 7, 1'b0), "no write");
    rename_one(make_req(7, 0, 8, 1'b1), "after no alloc");
  endtask

  task automatic test_exhaustion();
    rename_pkg::phys_reg_t pid;
    int                    n;
    n = 0;
    while (model_free.size() > 0) begin
      rename_one(make_req(n % 32, (n + 3) % 32, 1 + (n % 31), 1'b1), "drain");
      n++;
    end
    stalled_request(make_req(1, 2, 9, 1'b1), "empty dst");
    rename_one(make_req(1, 2, 9, 1'b0), "empty no dst");
    pid = model_held.pop_front();
    i_commit_valid = 1'b1;
    i_commit_pid   = pid;
    stalled_request(make_req(9, 9, 9, 1'b1), "commit cycle");  // push lands at this edge.
    i_commit_valid = 1'b0;
    model_free.push_back(pid);
    rename_one(make_req(9, 9, 9, 1'b1), "after commit");  // gets pid back.
  endtask

  task automatic test_random_mix();
    rename_pkg::rn_req_t   req;
    rename_pkg::phys_reg_t pid;
    int                    idx;
    for (int n = 0; n < 300; n++) begin
      rng_state = xorshift32(rng_state);
      if (model_held.size() > 0 && rng_state[3:0] < 4'd5) begin
        idx = int'(rng_state[15:8]) % model_held.size();
        pid = model_held[idx];
        model_held.delete(idx);
        commit_id(pid);
      end
      rng_state = xorshift32(rng_state);
      req = make_req(rng_state[4:0], rng_state[9:5], rng_state[14:10],
                     rng_state[16] | rng_state[17]);  // three in four write.
      if (writes_dst(req) && model_free.size() == 0) begin
        stalled_request(req, "random stall");
      end else begin
        rename_one(req, "random");
      end
    end
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////
  initial begin
    i_reset_n      = 1'b0;
    i_rn_valid     = 1'b0;
    i_rn_req       = '0;
    i_commit_valid = 1'b0;
    i_commit_pid   = '0;
    mismatch_count = 0;
    other_count    = 0;
    check_count    = 0;
    rng_state      = 32'd16;
    model_reset();
    repeat (10) @(posedge i_clk);
    @(negedge i_clk);
    i_reset_n = 1'b1;
    @(negedge i_clk);

    test_reset_identity();
    test_alloc_order();
    test_dependency();
    test_no_alloc();
    test_exhaustion();  // no commit before this point.
    test_random_mix();

    $display("checks %0d, mismatches %0d, other errors %0d",
             check_count, mismatch_count, other_count);
    if (mismatch_count == 0 && other_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

/* build.f */
+incdir+include
src/rename_pkg.sv
src/phys_freelist.sv
src/rename_map_table.sv
src/rename_stage.sv
src/rename_top.sv
sim/tb_rename_top.sv

/* Bender.yml */
package:
  name: rename_slice

sources:
  # rename slice rtl
  - include_dirs:
      - include
    files:
      - src/rename_pkg.sv
      - src/phys_freelist.sv
      - src/rename_map_table.sv
      - src/rename_stage.sv
      - src/rename_top.sv

  # directed testbench
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/tb_rename_top.sv
